// File: rtl/video_pkg.sv
// Shared frame timing, widths, pixel helpers and bus struct; imported by every video block
package video_pkg;

    // Beam positions and layer data
    typedef logic [7:0]  hpos_t;
    typedef logic [7:0]  vpos_t;
    typedef logic [1:0]  lpxl_t;
    typedef logic [11:0] color_t;
    typedef logic [2:0]  pal_idx_t;

    // Horizontal timing in pixels
    localparam hpos_t H_ACTIVE = 8'd64;
    localparam hpos_t H_TOTAL  = 8'd80;
    localparam hpos_t HS_START = 8'd68;
    localparam hpos_t HS_END   = 8'd71;

    // Vertical timing in lines
    localparam vpos_t V_ACTIVE = 8'd32;
    localparam vpos_t V_TOTAL  = 8'd40;
    localparam vpos_t VS_START = 8'd34;
    localparam vpos_t VS_END   = 8'd35;

    localparam int NUM_SPRITES = 4;
    localparam int MAP_COLS    = 8;

    // CPU and programming write port
    typedef struct packed {
        logic [8:0] addr;
        logic [7:0] data;
        logic       we;
    } wr_bus_t;

    // Four pixels per graphics byte, leftmost in the top bits
    function automatic lpxl_t pick_pxl(input logic [7:0] gfx, input logic [1:0] col);
        return gfx[{~col, 1'b1} -: 2];
    endfunction

endpackage

// File: rtl/video_timer.sv
// Beam counters with blanking and sync decode; drives position to the layers and the mixer
`timescale 1ns/1ps

module video_timer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pxl_cen,
    output video_pkg::hpos_t hdump,
    output video_pkg::vpos_t vdump,
    output logic           lhbl,
    output logic           lvbl,
    output logic           hs,
    output logic           vs
);
    import video_pkg::*;

    hpos_t h_nxt;
    vpos_t v_nxt;

    // Next beam position
    always_comb begin
        h_nxt = (hdump == H_TOTAL - 8'd1) ? 8'd0 : hdump + 8'd1;
        v_nxt = vdump;
        if (hdump == H_TOTAL - 8'd1) begin
            v_nxt = (vdump == V_TOTAL - 8'd1) ? 8'd0 : vdump + 8'd1;
        end
    end

    // Levels decoded from the next position so they line up with the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdump <= '0;
            vdump <= '0;
            lhbl  <= 1'b1;
            lvbl  <= 1'b1;
            hs    <= 1'b0;
            vs    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_nxt;
            vdump <= v_nxt;
            lhbl  <= h_nxt < H_ACTIVE;
            lvbl  <= v_nxt < V_ACTIVE;
            hs    <= (h_nxt >= HS_START) && (h_nxt <= HS_END);
            vs    <= (v_nxt >= VS_START) && (v_nxt <= VS_END);
        end
    end

endmodule

// File: rtl/tile_layer.sv
// Tile map and tile graphics ROM; outputs one registered 2-bit tile pixel per pixel tick
`timescale 1ns/1ps

module tile_layer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  video_pkg::wr_bus_t cpu,
    input  logic               vram_cs,
    input  video_pkg::wr_bus_t prog,
    input  logic               gfx_en,
    input  video_pkg::hpos_t   hdump,
    input  video_pkg::vpos_t   vdump,
    output video_pkg::lpxl_t   pxl
);
    import video_pkg::*;

    // Four rows of map bytes
    logic [7:0] vram [MAP_COLS * 4];
    logic [7:0] rom  [256];

    logic [4:0] map_idx;
    logic [3:0] code;
    logic [7:0] rom_addr;
    logic [7:0] gfx;

    always_ff @(posedge clk) begin
        if (cpu.we && vram_cs) begin
            vram[cpu.addr[4:0]] <= cpu.data;
        end
    end

    // Lower half of the programming space
    always_ff @(posedge clk) begin
        if (prog.we && gfx_en && !prog.addr[8]) begin
            rom[prog.addr[7:0]] <= prog.data;
        end
    end

    assign map_idx  = {vdump[4:3], hdump[5:3]};
    assign code     = vram[map_idx][3:0];
    assign rom_addr = {code, vdump[2:0], hdump[2]};
    assign gfx      = rom[rom_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= pick_pxl(gfx, hdump[1:0]);
        end
    end

endmodule

// File: rtl/sprite_layer.sv
// Object RAM, sprite graphics ROM and hit test; outputs the winning sprite pixel per tick
`timescale 1ns/1ps

module sprite_layer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  video_pkg::wr_bus_t cpu,
    input  logic               objram_cs,
    input  video_pkg::wr_bus_t prog,
    input  logic               gfx_en,
    input  video_pkg::hpos_t   hdump,
    input  video_pkg::vpos_t   vdump,
    output video_pkg::lpxl_t   pxl
);
    import video_pkg::*;

    // Four bytes per sprite: Y, X, code, enable
    logic [7:0] objram [NUM_SPRITES * 4];
    logic [7:0] rom    [256];

    hpos_t      dx  [NUM_SPRITES];
    vpos_t      dy  [NUM_SPRITES];
    lpxl_t      pix [NUM_SPRITES];
    logic       hit [NUM_SPRITES];
    lpxl_t      spr_nxt;

    always_ff @(posedge clk) begin
        if (cpu.we && objram_cs) begin
            objram[cpu.addr[3:0]] <= cpu.data;
        end
    end

    // Upper half of the programming space
    always_ff @(posedge clk) begin
        if (prog.we && gfx_en && prog.addr[8]) begin
            rom[prog.addr[7:0]] <= prog.data;
        end
    end

    for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_spr
        logic [3:0] code;
        logic [7:0] gfx;

        // Differences wrap, so sprites can hang off either edge
        assign dx[i]  = hdump - objram[4 * i + 1];
        assign dy[i]  = vdump - objram[4 * i];
        assign code   = objram[4 * i + 2][3:0];
        assign hit[i] = objram[4 * i + 3][0] && (dx[i] < 8'd8) && (dy[i] < 8'd8);
        assign gfx    = rom[{code, dy[i][2:0], dx[i][2]}];
        assign pix[i] = pick_pxl(gfx, dx[i][1:0]);
    end

    // Lowest index with an opaque pixel wins
    always_comb begin
        spr_nxt = '0;
        for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
            if (hit[i] && pix[i] != 2'd0) begin
                spr_nxt = pix[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= spr_nxt;
        end
    end

endmodule

// File: rtl/color_mixer.sv
// Layer priority and palette lookup; registers blanked RGB with matching delayed blanking
`timescale 1ns/1ps

module color_mixer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  video_pkg::wr_bus_t prog,
    input  logic               pal_en,
    input  video_pkg::lpxl_t   tile_pxl,
    input  video_pkg::lpxl_t   spr_pxl,
    input  logic               lhbl,
    input  logic               lvbl,
    output logic [3:0]         red,
    output logic [3:0]         green,
    output logic [3:0]         blue,
    output logic               lhbl_dly,
    output logic               lvbl_dly
);
    import video_pkg::*;

    color_t   pal_ram [8];
    pal_idx_t pal_idx;
    color_t   rgb;
    logic     lhbl_d1;
    logic     lvbl_d1;

    // Even byte carries red, odd byte green and blue
    always_ff @(posedge clk) begin
        if (prog.we && pal_en) begin
            if (prog.addr[0]) begin
                pal_ram[prog.addr[3:1]][7:0] <= prog.data;
            end else begin
                pal_ram[prog.addr[3:1]][11:8] <= prog.data[3:0];
            end
        end
    end

    assign pal_idx = (spr_pxl != 2'd0) ? {1'b1, spr_pxl} : {1'b0, tile_pxl};

    // First stage lines blanking up with the layer pixels
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            lhbl_d1  <= lhbl;
            lvbl_d1  <= lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            rgb      <= (lhbl_d1 && lvbl_d1) ? pal_ram[pal_idx] : '0;
        end
    end

    assign red   = rgb[11:8];
    assign green = rgb[7:4];
    assign blue  = rgb[3:0];

endmodule

// File: rtl/video_top.sv
// Video section top level; wires the beam timer, tile and sprite layers and the colour mixer
`timescale 1ns/1ps

module video_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  video_pkg::wr_bus_t cpu,
    input  logic               vram_cs,
    input  logic               objram_cs,
    input  video_pkg::wr_bus_t prog,
    input  logic               gfx_en,
    input  logic               pal_en,
    output logic               hs,
    output logic               vs,
    output logic               lhbl_dly,
    output logic               lvbl_dly,
    output logic [3:0]         red,
    output logic [3:0]         green,
    output logic [3:0]         blue
);
    import video_pkg::*;

    hpos_t hdump;
    vpos_t vdump;
    logic  lhbl;
    logic  lvbl;
    lpxl_t tile_pxl;
    lpxl_t spr_pxl;

    video_timer u_timer (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .pxl_cen ( pxl_cen  ),
        .hdump   ( hdump    ),
        .vdump   ( vdump    ),
        .lhbl    ( lhbl     ),
        .lvbl    ( lvbl     ),
        .hs      ( hs       ),
        .vs      ( vs       )
    );

    tile_layer u_tile (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .pxl_cen ( pxl_cen  ),
        .cpu     ( cpu      ),
        .vram_cs ( vram_cs  ),
        .prog    ( prog     ),
        .gfx_en  ( gfx_en   ),
        .hdump   ( hdump    ),
        .vdump   ( vdump    ),
        .pxl     ( tile_pxl )
    );

    sprite_layer u_sprite (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .cpu       ( cpu       ),
        .objram_cs ( objram_cs ),
        .prog      ( prog      ),
        .gfx_en    ( gfx_en    ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .pxl       ( spr_pxl   )
    );

    color_mixer u_mixer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .prog     ( prog     ),
        .pal_en   ( pal_en   ),
        .tile_pxl ( tile_pxl ),
        .spr_pxl  ( spr_pxl  ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

endmodule

// File: sim/video_props.sv
// Concurrent checks on sync, blanking and output quiet; bound into the video top level
`timescale 1ns/1ps

module video_props (
    input logic       clk,
    input logic       rst_n,
    input logic       pxl_cen,
    input logic       hs,
    input logic       vs,
    input logic       lvbl,
    input logic       lhbl_dly,
    input logic       lvbl_dly,
    input logic [3:0] red,
    input logic [3:0] green,
    input logic [3:0] blue
);

    // Length of the current sync pulse in pixel ticks
    logic [7:0] hs_len;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_len <= '0;
        end else if (pxl_cen) begin
            hs_len <= hs ? hs_len + 8'd1 : 8'd0;
        end
    end

    vs_in_vblank: assert property (@(posedge clk) disable iff (!rst_n) $rose(vs) |-> !lvbl)
        else $error("vs rose outside vertical blanking");

    hs_width: assert property (@(posedge clk) disable iff (!rst_n) $fell(hs) |-> hs_len == 8'd4)
        else $error("hs pulse was %0d ticks", hs_len);

    rgb_blank: assert property (@(posedge clk) disable iff (!rst_n)
        (!lhbl_dly || !lvbl_dly) |-> ({red, green, blue} == 12'h000))
        else $error("RGB not zero during blanking");

endmodule

bind video_top video_props u_props (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .pxl_cen  ( pxl_cen  ),
    .hs       ( hs       ),
    .vs       ( vs       ),
    .lvbl     ( lvbl     ),
    .lhbl_dly ( lhbl_dly ),
    .lvbl_dly ( lvbl_dly ),
    .red      ( red      ),
    .green    ( green    ),
    .blue     ( blue     )
);

// File: sim/video_tb.sv
// Directed testbench for the video section; runs the frame checks against a reference model
`timescale 1ns/1ps

module video_tb;
    import video_pkg::*;

    localparam int FRAME_TICKS = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int CLK_NS      = 40;
    localparam int TICK_NS     = 2 * CLK_NS;
    // Five frame-long tests of up to two frames each plus margin and bus writes
    localparam int WATCHDOG_NS = 14 * FRAME_TICKS * TICK_NS + 1500 * CLK_NS;

    logic       clk;
    logic       rst_n;
    logic       pxl_cen;
    wr_bus_t    cpu;
    wr_bus_t    prog;
    logic       vram_cs;
    logic       objram_cs;
    logic       gfx_en;
    logic       pal_en;
    logic       hs;
    logic       vs;
    logic       lhbl_dly;
    logic       lvbl_dly;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    int          tick_cnt;
    int          errors;
    int          checks;
    int          spr_shown;
    int          spr_holes;
    int          spr_overlap;
    logic [31:0] rng_state;

    // Reference copies of every memory in the DUT
    logic [7:0]  vram_m     [32];
    logic [7:0]  obj_m      [16];
    logic [7:0]  tile_rom_m [256];
    logic [7:0]  spr_rom_m  [256];
    logic [11:0] pal_m      [8];

    video_top u_dut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .cpu       ( cpu       ),
        .vram_cs   ( vram_cs   ),
        .objram_cs ( objram_cs ),
        .prog      ( prog      ),
        .gfx_en    ( gfx_en    ),
        .pal_en    ( pal_en    ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      )
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Pixel enable on every second clock
    always @(posedge clk) begin
        #2;
        pxl_cen <= ~pxl_cen;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= 0;
        end else if (pxl_cen) begin
            tick_cnt <= tick_cnt + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the video checks did not finish in the expected time");
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // Leftmost pixel sits in bits 7:6
    function automatic logic [1:0] gfx_pixel(input logic [7:0] gfx, input int col);
        logic [7:0] sh;
        sh = gfx >> (6 - 2 * col);
        return sh[1:0];
    endfunction

    function automatic void expected_pixel(input int h, input int v, output logic [11:0] color,
                                           output int n_opaque, output logic in_sprite);
        logic [7:0] gfx;
        logic [7:0] dx;
        logic [7:0] dy;
        logic [1:0] tp;
        logic [1:0] sp;
        logic [1:0] p;
        int         code;
        code = int'(vram_m[(v / 8) * MAP_COLS + h / 8][3:0]);
        gfx  = tile_rom_m[code * 16 + (v % 8) * 2 + (h % 8) / 4];
        tp   = gfx_pixel(gfx, h % 4);
        sp        = 2'd0;
        n_opaque  = 0;
        in_sprite = 1'b0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            dx = 8'(h - int'(obj_m[4 * i + 1]));
            dy = 8'(v - int'(obj_m[4 * i]));
            if (obj_m[4 * i + 3][0] && dx < 8'd8 && dy < 8'd8) begin
                in_sprite = 1'b1;
                code = int'(obj_m[4 * i + 2][3:0]);
                gfx  = spr_rom_m[code * 16 + int'(dy) * 2 + int'(dx) / 4];
                p    = gfx_pixel(gfx, int'(dx) % 4);
                if (p != 2'd0) begin
                    n_opaque++;
                    if (sp == 2'd0) begin
                        sp = p;
                    end
                end
            end
        end
        color = (sp != 2'd0) ? pal_m[4 + int'(sp)] : pal_m[int'(tp)];
    endfunction

    // Waits for the next pixel tick and returns where outputs have settled
    task automatic next_tick();
        int start;
        start = tick_cnt;
        while (tick_cnt == start) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic cpu_write(input int addr, input logic [7:0] data, input logic vsel,
                             input logic osel);
        cpu.addr  = 9'(addr);
        cpu.data  = data;
        cpu.we    = 1'b1;
        vram_cs   = vsel;
        objram_cs = osel;
        @(posedge clk);
        #2;
        cpu.we    = 1'b0;
        vram_cs   = 1'b0;
        objram_cs = 1'b0;
    endtask

    task automatic prog_write(input int addr, input logic [7:0] data, input logic gsel,
                              input logic psel);
        prog.addr = 9'(addr);
        prog.data = data;
        prog.we   = 1'b1;
        gfx_en    = gsel;
        pal_en    = psel;
        @(posedge clk);
        #2;
        prog.we = 1'b0;
        gfx_en  = 1'b0;
        pal_en  = 1'b0;
    endtask

    task automatic write_vram(input int addr, input logic [7:0] data);
        vram_m[addr] = data;
        cpu_write(addr, data, 1'b1, 1'b0);
    endtask

    task automatic write_obj(input int addr, input logic [7:0] data);
        obj_m[addr] = data;
        cpu_write(addr, data, 1'b0, 1'b1);
    endtask

    // Bit 8 of the address picks the sprite ROM
    task automatic write_gfx(input int addr, input logic [7:0] data);
        if (addr >= 256) begin
            spr_rom_m[addr - 256] = data;
        end else begin
            tile_rom_m[addr] = data;
        end
        prog_write(addr, data, 1'b1, 1'b0);
    endtask

    task automatic write_pal(input int idx, input logic [11:0] c);
        pal_m[idx] = c;
        prog_write(idx * 2, {4'b0, c[11:8]}, 1'b0, 1'b1);
        prog_write(idx * 2 + 1, c[7:0], 1'b0, 1'b1);
    endtask

    task automatic set_sprite(input int i, input int x, input int y, input int code,
                              input logic en);
        write_obj(4 * i, 8'(y));
        write_obj(4 * i + 1, 8'(x));
        write_obj(4 * i + 2, 8'(code));
        write_obj(4 * i + 3, {7'b0, en});
    endtask

    // Output position lags the beam by two ticks
    task automatic compare_frame();
        int         p;
        int         h;
        int         v;
        int         n_opaque;
        logic       in_sprite;
        logic [11:0] exp_c;
        while ((tick_cnt - 2) % FRAME_TICKS != FRAME_TICKS - 200) begin
            next_tick();
        end
        while ((tick_cnt - 2) % FRAME_TICKS != 0) begin
            next_tick();
        end
        for (int n = 0; n < FRAME_TICKS; n++) begin
            p = (tick_cnt - 2) % FRAME_TICKS;
            h = p % int'(H_TOTAL);
            v = p / int'(H_TOTAL);
            exp_c = 12'h000;
            if (h < int'(H_ACTIVE) && v < int'(V_ACTIVE)) begin
                expected_pixel(h, v, exp_c, n_opaque, in_sprite);
                if (n_opaque > 0) spr_shown++;
                if (in_sprite && n_opaque == 0) spr_holes++;
                if (n_opaque > 1) spr_overlap++;
            end
            check("rgb", 32'(exp_c), 32'({red, green, blue}));
            check("lhbl_dly", 32'(h < int'(H_ACTIVE)), 32'(lhbl_dly));
            check("lvbl_dly", 32'(v < int'(V_ACTIVE)), 32'(lvbl_dly));
            next_tick();
        end
    endtask

    task automatic test_reset();
        rst_n = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #2;
            check("rgb", 32'd0, 32'({red, green, blue}));
            check("lhbl_dly", 32'd0, 32'(lhbl_dly));
            check("lvbl_dly", 32'd0, 32'(lvbl_dly));
            check("hs", 32'd0, 32'(hs));
            check("vs", 32'd0, 32'(vs));
        end
        rst_n = 1'b1;
        next_tick();
        check("rgb", 32'd0, 32'({red, green, blue}));
        check("lhbl_dly", 32'd0, 32'(lhbl_dly));
        check("lvbl_dly", 32'd0, 32'(lvbl_dly));
        check("hs", 32'd0, 32'(hs));
        check("vs", 32'd0, 32'(vs));
    endtask

    task automatic test_sync();
        int   hs_cnt;
        int   vs_cnt;
        int   lhbl_cnt;
        int   rise_pos;
        logic vs_prev;
        hs_cnt   = 0;
        vs_cnt   = 0;
        lhbl_cnt = 0;
        rise_pos = -1;
        while (tick_cnt % FRAME_TICKS != 0) begin
            next_tick();
        end
        vs_prev = vs;
        for (int n = 0; n < FRAME_TICKS; n++) begin
            next_tick();
            if (hs) hs_cnt++;
            if (vs) vs_cnt++;
            if (lhbl_dly) lhbl_cnt++;
            if (vs && !vs_prev && rise_pos < 0) begin
                rise_pos = tick_cnt % FRAME_TICKS;
            end
            vs_prev = vs;
        end
        check("hs_ticks", 32'((int'(HS_END) - int'(HS_START) + 1) * int'(V_TOTAL)), 32'(hs_cnt));
        check("vs_ticks", 32'((int'(VS_END) - int'(VS_START) + 1) * int'(H_TOTAL)), 32'(vs_cnt));
        check("lhbl_dly_ticks", 32'(int'(H_ACTIVE) * int'(V_TOTAL)), 32'(lhbl_cnt));
        check("vs_rise_pos", 32'(int'(VS_START) * int'(H_TOTAL)), 32'(rise_pos));
    endtask

    task automatic test_tiles();
        for (int i = 0; i < 8; i++) write_pal(i, 12'(rand32()));
        for (int a = 0; a < 256; a++) write_gfx(a, 8'(rand32()));
        for (int a = 0; a < 32; a++) write_vram(a, 8'(rand32()));
        for (int i = 0; i < NUM_SPRITES; i++) set_sprite(i, 0, 0, 0, 1'b0);
        compare_frame();
    endtask

    task automatic test_sprites();
        for (int a = 256; a < 512; a++) write_gfx(a, 8'(rand32()));
        // Code 3 row 0 holds one pixel of each value
        write_gfx(256 + 3 * 16, 8'h1b);
        set_sprite(0, 20, 10, 3, 1'b1);
        set_sprite(1, 60, 28, 5, 1'b1);
        spr_shown = 0;
        spr_holes = 0;
        compare_frame();
        if (spr_shown == 0 || spr_holes == 0) begin
            errors++;
            $display("Sprite frame lacked opaque or transparent sprite pixels to check");
        end
    endtask

    task automatic test_priority();
        // Sprite 0 drawn all in value 1 and sprite 2 all in value 2
        for (int a = 0; a < 16; a++) begin
            write_gfx(256 + 3 * 16 + a, 8'h55);
            write_gfx(256 + 6 * 16 + a, 8'haa);
        end
        // Distinct colours for the two sprite values
        write_pal(6, ~pal_m[5]);
        set_sprite(1, 0, 0, 0, 1'b0);
        set_sprite(0, 30, 12, 3, 1'b1);
        set_sprite(2, 32, 14, 6, 1'b1);
        spr_overlap = 0;
        compare_frame();
        if (spr_overlap == 0) begin
            errors++;
            $display("Sprites 0 and 2 never overlapped with opaque pixels");
        end
    endtask

    task automatic test_rewrite();
        write_pal(0, 12'h0f0);
        write_pal(5, 12'hf0f);
        for (int a = 0; a < 32; a += 3) write_vram(a, 8'(rand32()));
        compare_frame();
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        cpu       = '0;
        prog      = '0;
        vram_cs   = 1'b0;
        objram_cs = 1'b0;
        gfx_en    = 1'b0;
        pal_en    = 1'b0;
        errors    = 0;
        checks    = 0;
        rng_state = 32'hde89;

        test_reset();
        test_sync();
        test_tiles();
        test_sprites();
        test_priority();
        test_rewrite();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/video_pkg.sv
rtl/video_timer.sv
rtl/tile_layer.sv
rtl/sprite_layer.sv
rtl/color_mixer.sv
rtl/video_top.sv
sim/video_props.sv
sim/video_tb.sv

// File: Makefile
SRCS := $(shell cat vlog.f)

obj_dir/Vvideo_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module video_tb -f vlog.f

.PHONY: run clean

run: obj_dir/Vvideo_tb
	@out="$$(./obj_dir/Vvideo_tb)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
